// File: bench/tb_core.sv
/*
 * Core testbench
 * Loads small programs into the memory model, runs the core
 * until EBREAK and checks the stores and memory contents.
 */
module tb_core;
    timeunit 1ns;
    timeprecision 1ps;

    logic                      clk = 1'b0;
    logic                      rst = 1'b1;
    logic                      imem_req;
    logic                      imem_valid;
    logic [core_pkg::XLEN-1:0] imem_addr;
    logic [31:0]               imem_rdata;
    logic                      dmem_req;
    logic                      dmem_we;
    logic                      dmem_done;
    logic [core_pkg::XLEN-1:0] dmem_addr;
    logic [core_pkg::XLEN-1:0] dmem_wdata;
    logic [core_pkg::XLEN-1:0] dmem_rdata;
    logic [3:0]                dmem_wstrb;
    logic                      halted;
    logic [31:0]               prog_pc;
    int                        errors = 0;
    int                        tests = 0;
    int                        failed = 0;
    int                        late_req = 0;

    localparam logic [31:0] DATA = 32'h400;
    localparam logic [31:0] EBREAK = 32'h0010_0073;

    always #4 clk = ~clk;

    core_top dut (
        .clk(clk), .rst(rst), .imem_valid(imem_valid), .imem_rdata(imem_rdata),
        .dmem_done(dmem_done), .dmem_rdata(dmem_rdata), .imem_req(imem_req),
        .imem_addr(imem_addr), .dmem_req(dmem_req), .dmem_we(dmem_we),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_wstrb(dmem_wstrb),
        .halted(halted)
    );

    tb_memory mem_model (
        .clk(clk), .rst(rst), .imem_req(imem_req), .imem_addr(imem_addr),
        .imem_valid(imem_valid), .imem_rdata(imem_rdata), .dmem_req(dmem_req),
        .dmem_we(dmem_we), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .dmem_wstrb(dmem_wstrb), .dmem_done(dmem_done), .dmem_rdata(dmem_rdata)
    );

    // Any request once the core has stopped
    always @(negedge clk) begin
        if (!rst && halted && (imem_req || dmem_req)) late_req++;
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, isa_pkg::OP_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input isa_pkg::opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], isa_pkg::OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], isa_pkg::OP_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, isa_pkg::OP_JAL};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
            input logic [11:0] imm);
        return i_type(imm, rs1, 3'b000, rd, isa_pkg::OP_IMM);
    endfunction

    task automatic emit(input logic [31:0] word);
        mem_model.write_word(prog_pc, word);
        prog_pc += 4;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic new_program();
        mem_model.fill_pattern();
        prog_pc = 0;
    endtask

    // Reset the core, then wait for EBREAK
    task automatic run_program();
        int cycles;
        @(negedge clk);
        rst = 1'b1;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        late_req = 0;
        cycles = 0;
        while (!halted && cycles < 5000) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("Core did not halt within %0d cycles", cycles);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors != errs_before) failed++;
        $display("%s: %s", name, (errors == errs_before) ? "pass" : "fail");
    endtask

    task automatic alu_ops_test(input string name, input bit rnd);
        int errs;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [4:0] regs [16];
        logic [31:0] exp [16];
        errs = errors;
        a = 32'hffff_fff9;
        b = 32'd13;
        c = 32'h1234_5000;
        regs = '{1, 2, 3, 4, 5, 6, 7, 8, 9, 11, 13, 14, 15, 16, 17, 18};
        exp = '{a, b, c, a + b, a - b, {31'b0, $signed(a) < $signed(b)},
                {31'b0, $signed(b) < $signed(a)}, c ^ b, c | a, c & a, c << 4, a >> 4,
                {31'b0, $signed(a) < -3}, a ^ 32'h0f0, b | 32'h700, a & 32'hff};
        new_program();
        mem_model.set_delays(1, 1, rnd);
        emit(addi(1, 0, -7));
        emit(addi(2, 0, 13));
        emit({20'h12345, 5'd3, isa_pkg::OP_LUI});
        emit(addi(10, 0, 12'h400));
        emit(addi(12, 0, 4));
        emit(r_type(7'h00, 2, 1, 3'b000, 4));
        emit(r_type(7'h20, 2, 1, 3'b000, 5));
        emit(r_type(7'h00, 2, 1, 3'b010, 6));
        emit(r_type(7'h00, 1, 2, 3'b010, 7));
        emit(r_type(7'h00, 2, 3, 3'b100, 8));
        emit(r_type(7'h00, 1, 3, 3'b110, 9));
        emit(r_type(7'h00, 1, 3, 3'b111, 11));
        emit(r_type(7'h00, 12, 3, 3'b001, 13));
        emit(r_type(7'h00, 12, 1, 3'b101, 14));
        emit(i_type(-3, 1, 3'b010, 15, isa_pkg::OP_IMM));
        emit(i_type(12'h0f0, 1, 3'b100, 16, isa_pkg::OP_IMM));
        emit(i_type(12'h700, 2, 3'b110, 17, isa_pkg::OP_IMM));
        emit(i_type(12'h0ff, 1, 3'b111, 18, isa_pkg::OP_IMM));
        for (int k = 0; k < 16; k++) emit(s_type(4 * k, regs[k], 10, 3'b010));
        emit(EBREAK);
        run_program();
        check_value("store count", mem_model.st_addr.size(), 16);
        for (int k = 0; k < 16; k++) begin
            check_value($sformatf("mem[%h]", DATA + 4 * k), mem_model.mem[256 + k], exp[k]);
        end
        repeat (20) @(negedge clk);
        check_value("requests after halted", late_req, 0);
        report_test(name, errs);
    endtask

    task automatic branch_test();
        int errs;
        logic [31:0] link;
        logic [31:0] offs [5];
        errs = errors;
        offs = '{4, 12, 24, 28, 36};
        new_program();
        mem_model.set_delays(2, 2, 0);
        emit(addi(1, 0, 5));
        emit(addi(2, 0, 5));
        emit(addi(3, 0, -1));
        emit(addi(10, 0, 12'h400));
        emit(addi(20, 0, 1));
        emit(b_type(8, 2, 1, 3'b000));     // BEQ taken
        emit(s_type(0, 20, 10, 3'b010));
        emit(b_type(8, 2, 1, 3'b001));     // BNE not taken
        emit(s_type(4, 20, 10, 3'b010));
        emit(b_type(8, 1, 3, 3'b100));     // BLT taken, -1 < 5
        emit(s_type(8, 20, 10, 3'b010));
        emit(b_type(8, 1, 3, 3'b101));     // BGE not taken
        emit(s_type(12, 20, 10, 3'b010));
        emit(b_type(8, 3, 1, 3'b001));     // BNE taken
        emit(s_type(16, 20, 10, 3'b010));
        emit(b_type(8, 3, 1, 3'b101));     // BGE taken
        emit(s_type(20, 20, 10, 3'b010));
        emit(b_type(8, 3, 1, 3'b000));     // BEQ not taken
        emit(s_type(24, 20, 10, 3'b010));
        emit(b_type(8, 3, 1, 3'b100));     // BLT not taken
        emit(s_type(28, 20, 10, 3'b010));
        link = prog_pc + 4;
        emit(j_type(8, 5));
        emit(s_type(32, 20, 10, 3'b010));
        emit(s_type(36, 5, 10, 3'b010));
        emit(EBREAK);
        run_program();
        check_value("store count", mem_model.st_addr.size(), 5);
        for (int k = 0; k < 5 && k < mem_model.st_addr.size(); k++) begin
            check_value("dmem_addr", mem_model.st_addr[k], DATA + offs[k]);
            check_value("dmem_wdata", mem_model.st_data[k], (k == 4) ? link : 32'd1);
        end
        report_test("branches and jump", errs);
    endtask

    task automatic byte_test();
        int errs;
        logic [31:0] exp [5];
        errs = errors;
        exp = '{32'hffff_ff81, 32'h81, 32'hffff_ffa4, 32'ha4, 32'ha417_4281};
        new_program();
        mem_model.set_delays(1, 3, 0);
        mem_model.write_word(DATA, 32'h0);
        emit(addi(10, 0, 12'h400));
        emit(addi(1, 0, 12'h081));
        emit(addi(2, 0, 12'h042));
        emit(addi(3, 0, 12'h017));
        emit(addi(4, 0, -12'h05c));
        for (int k = 0; k < 4; k++) emit(s_type(k, k + 1, 10, 3'b000));
        emit(i_type(0, 10, 3'b000, 5, isa_pkg::OP_LOAD));
        emit(i_type(0, 10, 3'b100, 6, isa_pkg::OP_LOAD));
        emit(i_type(3, 10, 3'b000, 7, isa_pkg::OP_LOAD));
        emit(i_type(3, 10, 3'b100, 8, isa_pkg::OP_LOAD));
        emit(i_type(0, 10, 3'b010, 9, isa_pkg::OP_LOAD));
        for (int k = 0; k < 5; k++) emit(s_type(4 * (k + 1), k + 5, 10, 3'b010));
        emit(EBREAK);
        run_program();
        check_value("store count", mem_model.st_addr.size(), 9);
        for (int k = 0; k < 4 && k < mem_model.st_strb.size(); k++) begin
            check_value("dmem_wstrb", mem_model.st_strb[k], 32'd1 << k);
        end
        check_value("mem[400]", mem_model.mem[256], 32'ha417_4281);
        for (int k = 0; k < 5; k++) begin
            check_value($sformatf("mem[%h]", DATA + 4 * (k + 1)), mem_model.mem[257 + k],
                        exp[k]);
        end
        report_test("byte loads and stores", errs);
    endtask

    task automatic x0_test();
        int errs;
        errs = errors;
        new_program();
        mem_model.set_delays(1, 1, 0);
        emit(addi(10, 0, 12'h400));
        emit(addi(1, 0, 5));
        emit(addi(0, 0, 123));
        emit({20'habcde, 5'd0, isa_pkg::OP_LUI});
        emit(r_type(7'h00, 1, 1, 3'b000, 0));
        emit(s_type(0, 0, 10, 3'b010));
        emit(EBREAK);
        run_program();
        check_value("store count", mem_model.st_addr.size(), 1);
        check_value("mem[400]", mem_model.mem[256], 32'h0);
        report_test("x0 constant", errs);
    endtask

    initial begin
        repeat (3) @(negedge clk);
        alu_ops_test("alu operations", 0);
        branch_test();
        byte_test();
        x0_test();
        alu_ops_test("variable latency", 1);
        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: bench/tb_memory.sv
/*
 * Memory model for the core testbench
 * One word array serves the instruction and data ports.
 * Answers each request after a fixed or random delay and
 * keeps a log of every store.
 */
module tb_memory (
    input  logic        clk,
    input  logic        rst,
    input  logic        imem_req,
    input  logic [31:0] imem_addr,
    output logic        imem_valid,
    output logic [31:0] imem_rdata,
    input  logic        dmem_req,
    input  logic        dmem_we,
    input  logic [31:0] dmem_addr,
    input  logic [31:0] dmem_wdata,
    input  logic [3:0]  dmem_wstrb,
    output logic        dmem_done,
    output logic [31:0] dmem_rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] mem [1024];
    logic [31:0] st_addr [$];
    logic [31:0] st_data [$];
    logic [3:0]  st_strb [$];
    int          imem_delay = 1;
    int          dmem_delay = 1;
    bit          random_delay = 0;
    bit          seeded = 0;
    int          icount = 0;
    int          dcount = 0;
    int          ipend;
    int          dpend;

    initial begin
        imem_valid = 1'b0;
        imem_rdata = '0;
        dmem_done  = 1'b0;
        dmem_rdata = '0;
    end

    function automatic int pick_delay(input int fixed);
        if (random_delay) begin
            return $urandom_range(4, 1);
        end
        return fixed;
    endfunction

    // Fill pattern mixes every address bit
    task automatic fill_pattern();
        for (int i = 0; i < 1024; i++) begin
            mem[i] = (i * 32'h9e3779b1) ^ 32'ha5c3_0f11;
        end
        st_addr.delete();
        st_data.delete();
        st_strb.delete();
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        mem[addr[11:2]] = data;
    endtask

    task automatic set_delays(input int i_dly, input int d_dly, input bit rnd);
        imem_delay   = i_dly;
        dmem_delay   = d_dly;
        random_delay = rnd;
    endtask

    // Requests are sampled and answers driven on the falling edge
    always @(negedge clk) begin
        if (!seeded) begin
            // Random delays are drawn by this process
            void'($urandom(32'h5eefde3b));
            seeded = 1'b1;
        end
        imem_valid = 1'b0;
        dmem_done  = 1'b0;
        if (rst) begin
            icount = 0;
            dcount = 0;
        end else begin
            if (icount > 0) begin
                icount--;
                if (icount == 0) begin
                    imem_valid = 1'b1;
                    imem_rdata = mem[ipend];
                end
            end
            if (dcount > 0) begin
                dcount--;
                if (dcount == 0) begin
                    dmem_done  = 1'b1;
                    dmem_rdata = mem[dpend];
                end
            end
            if (imem_req) begin
                ipend  = imem_addr[11:2];
                icount = pick_delay(imem_delay);
            end
            if (dmem_req) begin
                dpend  = dmem_addr[11:2];
                dcount = pick_delay(dmem_delay);
                if (dmem_we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (dmem_wstrb[b]) mem[dpend][8*b +: 8] = dmem_wdata[8*b +: 8];
                    end
                    st_addr.push_back(dmem_addr);
                    st_data.push_back(dmem_wdata);
                    st_strb.push_back(dmem_wstrb);
                end
            end
        end
    end

endmodule

// File: flist.f
hw/core_pkg.sv
hw/isa_pkg.sv
hw/instr_sequencer.sv
hw/decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/load_store_unit.sv
hw/core_top.sv
bench/tb_memory.sv
bench/tb_core.sv

// File: hw/alu.sv
/*
 * ALU
 * Integer operations for OP and OP-IMM, address generation
 * for loads and stores, and the signed branch compare
 */
module alu (
    input  isa_pkg::alu_op_t          alu_op,
    input  logic [core_pkg::XLEN-1:0] operand_a,
    input  logic [core_pkg::XLEN-1:0] operand_b,
    input  isa_pkg::branch_t          branch_cond,
    input  logic                      is_branch,
    output logic [core_pkg::XLEN-1:0] result,
    output logic                      branch_taken
);

    logic       equal;
    logic       less;
    logic       cond_met;
    logic [4:0] shamt;

    assign equal = (operand_a == operand_b);
    assign less  = ($signed(operand_a) < $signed(operand_b));
    assign shamt = operand_b[4:0];

    always_comb begin
        case (alu_op)
            isa_pkg::ALU_ADD: result = operand_a + operand_b;
            isa_pkg::ALU_SUB: result = operand_a - operand_b;
            isa_pkg::ALU_SLT: result = {{(core_pkg::XLEN-1){1'b0}}, less};
            isa_pkg::ALU_XOR: result = operand_a ^ operand_b;
            isa_pkg::ALU_OR:  result = operand_a | operand_b;
            isa_pkg::ALU_AND: result = operand_a & operand_b;
            isa_pkg::ALU_SLL: result = operand_a << shamt;
            isa_pkg::ALU_SRL: result = operand_a >> shamt;
            default:          result = '0;
        endcase
    end

    always_comb begin
        case (branch_cond)
            isa_pkg::BR_EQ: cond_met = equal;
            isa_pkg::BR_NE: cond_met = !equal;
            isa_pkg::BR_LT: cond_met = less;
            isa_pkg::BR_GE: cond_met = !less;
            default:        cond_met = 1'b0;
        endcase
    end

    // Only real branches redirect the PC
    assign branch_taken = is_branch && cond_met;

endmodule

// File: hw/core_pkg.sv
/*
 * Core package
 * Machine widths, register count, reset PC and the
 * write-back source selection shared by the core units
 */
package core_pkg;

    // Data and address width
    localparam int XLEN = 32;

    // Register index width and register count
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS = 1 << REG_ADDR_W;

    // First fetch address after reset
    localparam logic [XLEN-1:0] RESET_PC = '0;

    // Source of the value written to rd
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2,   // link value for JAL
        WB_IMM = 2'd3    // LUI
    } wb_src_t;

endpackage

// File: hw/core_top.sv
/*
 * Core top
 * Single-issue RV32I subset core. Connects sequencer,
 * decoder, register file, ALU and load/store unit, and
 * selects the operand and write-back sources.
 */
module core_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      imem_valid,
    input  logic [31:0]               imem_rdata,
    input  logic                      dmem_done,
    input  logic [core_pkg::XLEN-1:0] dmem_rdata,
    output logic                      imem_req,
    output logic [core_pkg::XLEN-1:0] imem_addr,
    output logic                      dmem_req,
    output logic                      dmem_we,
    output logic [core_pkg::XLEN-1:0] dmem_addr,
    output logic [core_pkg::XLEN-1:0] dmem_wdata,
    output logic [3:0]                dmem_wstrb,
    output logic                      halted
);

    logic [31:0]                     inst;
    logic [core_pkg::REG_ADDR_W-1:0] rs1;
    logic [core_pkg::REG_ADDR_W-1:0] rs2;
    logic [core_pkg::REG_ADDR_W-1:0] rd;
    logic [core_pkg::XLEN-1:0]       imm;
    logic [core_pkg::XLEN-1:0]       pc;
    logic [core_pkg::XLEN-1:0]       rs1_data;
    logic [core_pkg::XLEN-1:0]       rs2_data;
    logic [core_pkg::XLEN-1:0]       operand_b;
    logic [core_pkg::XLEN-1:0]       alu_result;
    logic [core_pkg::XLEN-1:0]       load_data;
    logic [core_pkg::XLEN-1:0]       wb_data;
    isa_pkg::alu_op_t                alu_op;
    isa_pkg::branch_t                branch_cond;
    isa_pkg::mem_size_t              mem_size;
    core_pkg::wb_src_t               wb_src;
    logic alu_use_imm;
    logic is_branch;
    logic is_jump;
    logic is_mem;
    logic is_store;
    logic is_halt;
    logic rd_w_en;
    logic rf_we_en;
    logic branch_taken;
    logic mem_start;
    logic mem_done;

    instr_sequencer u_seq (
        .clk(clk), .rst(rst),
        .imem_valid(imem_valid), .imem_rdata(imem_rdata),
        .is_mem(is_mem), .is_halt(is_halt),
        .branch_taken(branch_taken), .is_jump(is_jump),
        .imm(imm), .mem_done(mem_done),
        .imem_req(imem_req), .imem_addr(imem_addr), .inst(inst),
        .mem_start(mem_start), .rf_we_en(rf_we_en), .pc(pc), .halted(halted)
    );

    decoder u_dec (
        .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
        .alu_op(alu_op), .alu_use_imm(alu_use_imm),
        .branch_cond(branch_cond), .is_branch(is_branch), .is_jump(is_jump),
        .is_mem(is_mem), .is_store(is_store), .mem_size(mem_size),
        .rd_w_en(rd_w_en), .wb_src(wb_src), .is_halt(is_halt)
    );

    // Register write only when the instruction retires
    reg_file u_rf (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd),
        .we(rf_we_en && rd_w_en), .wdata(wb_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    assign operand_b = alu_use_imm ? imm : rs2_data;

    alu u_alu (
        .alu_op(alu_op), .operand_a(rs1_data), .operand_b(operand_b),
        .branch_cond(branch_cond), .is_branch(is_branch),
        .result(alu_result), .branch_taken(branch_taken)
    );

    load_store_unit u_lsu (
        .clk(clk), .rst(rst), .mem_start(mem_start), .is_store(is_store),
        .mem_size(mem_size), .addr(alu_result), .store_data(rs2_data),
        .dmem_done(dmem_done), .dmem_rdata(dmem_rdata),
        .dmem_req(dmem_req), .dmem_we(dmem_we), .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata), .dmem_wstrb(dmem_wstrb),
        .mem_done(mem_done), .load_data(load_data)
    );

    always_comb begin
        case (wb_src)
            core_pkg::WB_MEM: wb_data = load_data;
            core_pkg::WB_PC4: wb_data = pc + 32'd4;
            core_pkg::WB_IMM: wb_data = imm;
            default:          wb_data = alu_result;
        endcase
    end

endmodule

// File: hw/decoder.sv
/*
 * Instruction decoder
 * Splits the instruction fields, builds the immediates and
 * derives the control signals for the kept RV32I subset.
 * Unknown opcodes fall through as a PC-only no-op.
 */
module decoder (
    input  logic [31:0]                     inst,
    output logic [core_pkg::REG_ADDR_W-1:0] rs1,
    output logic [core_pkg::REG_ADDR_W-1:0] rs2,
    output logic [core_pkg::REG_ADDR_W-1:0] rd,
    output logic [core_pkg::XLEN-1:0]       imm,
    output isa_pkg::alu_op_t                alu_op,
    output logic                            alu_use_imm,
    output isa_pkg::branch_t                branch_cond,
    output logic                            is_branch,
    output logic                            is_jump,
    output logic                            is_mem,
    output logic                            is_store,
    output isa_pkg::mem_size_t              mem_size,
    output logic                            rd_w_en,
    output core_pkg::wb_src_t               wb_src,
    output logic                            is_halt
);

    isa_pkg::opcode_t          opcode;
    isa_pkg::alu_op_t          alu_func;
    logic [2:0]                funct3;
    logic [core_pkg::XLEN-1:0] imm_i;
    logic [core_pkg::XLEN-1:0] imm_s;
    logic [core_pkg::XLEN-1:0] imm_b;
    logic [core_pkg::XLEN-1:0] imm_u;
    logic [core_pkg::XLEN-1:0] imm_j;

    assign opcode = isa_pkg::opcode_t'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // funct3 encodings match between branch, load/store and the enums
    assign branch_cond = isa_pkg::branch_t'(funct3);
    assign mem_size    = isa_pkg::mem_size_t'(funct3);

    // ALU function of OP and OP-IMM; bit 30 selects SUB only for OP
    always_comb begin
        case (funct3)
            3'b000:  alu_func = (opcode == isa_pkg::OP_REG && inst[30]) ? isa_pkg::ALU_SUB
                                                                        : isa_pkg::ALU_ADD;
            3'b001:  alu_func = isa_pkg::ALU_SLL;
            3'b010:  alu_func = isa_pkg::ALU_SLT;
            3'b100:  alu_func = isa_pkg::ALU_XOR;
            3'b101:  alu_func = isa_pkg::ALU_SRL;
            3'b110:  alu_func = isa_pkg::ALU_OR;
            3'b111:  alu_func = isa_pkg::ALU_AND;
            default: alu_func = isa_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        imm         = imm_i;
        alu_op      = isa_pkg::ALU_ADD;
        alu_use_imm = 1'b0;
        is_branch   = 1'b0;
        is_jump     = 1'b0;
        is_mem      = 1'b0;
        is_store    = 1'b0;
        rd_w_en     = 1'b0;
        wb_src      = core_pkg::WB_ALU;
        is_halt     = 1'b0;
        case (opcode)
            isa_pkg::OP_LUI: begin
                imm     = imm_u;
                rd_w_en = 1'b1;
                wb_src  = core_pkg::WB_IMM;
            end
            isa_pkg::OP_JAL: begin
                imm     = imm_j;
                is_jump = 1'b1;
                rd_w_en = 1'b1;
                wb_src  = core_pkg::WB_PC4;
            end
            isa_pkg::OP_BRANCH: begin
                imm       = imm_b;
                is_branch = 1'b1;
            end
            isa_pkg::OP_LOAD: begin
                alu_use_imm = 1'b1;
                is_mem      = 1'b1;
                rd_w_en     = 1'b1;
                wb_src      = core_pkg::WB_MEM;
            end
            isa_pkg::OP_STORE: begin
                imm         = imm_s;
                alu_use_imm = 1'b1;
                is_mem      = 1'b1;
                is_store    = 1'b1;
            end
            isa_pkg::OP_IMM: begin
                alu_op      = alu_func;
                alu_use_imm = 1'b1;
                rd_w_en     = 1'b1;
            end
            isa_pkg::OP_REG: begin
                alu_op  = alu_func;
                rd_w_en = 1'b1;
            end
            // EBREAK only, other SYSTEM forms are no-ops
            isa_pkg::OP_SYSTEM: is_halt = (inst[31:20] == 12'h001) && (funct3 == 3'b000);
            default: ;
        endcase
    end

endmodule

// File: hw/instr_sequencer.sv
/*
 * Instruction sequencer
 * Holds the PC, runs the fetch handshake and steps one
 * instruction at a time through execute and the optional
 * data access. Stops for good on EBREAK.
 */
module instr_sequencer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      imem_valid,
    input  logic [31:0]               imem_rdata,
    input  logic                      is_mem,
    input  logic                      is_halt,
    input  logic                      branch_taken,
    input  logic                      is_jump,
    input  logic [core_pkg::XLEN-1:0] imm,
    input  logic                      mem_done,
    output logic                      imem_req,
    output logic [core_pkg::XLEN-1:0] imem_addr,
    output logic [31:0]               inst,
    output logic                      mem_start,
    output logic                      rf_we_en,
    output logic [core_pkg::XLEN-1:0] pc,
    output logic                      halted
);

    typedef enum logic [2:0] {FETCH, WAIT_INST, EXEC, WAIT_MEM, HALT} state_t;

    state_t                    state;
    state_t                    next_state;
    logic                      retire;
    logic [core_pkg::XLEN-1:0] next_pc;

    always_comb begin
        next_state = state;
        case (state)
            FETCH:     if (imem_req) next_state = WAIT_INST;
            WAIT_INST: if (imem_valid) next_state = EXEC;
            EXEC: begin
                if (is_halt) begin
                    next_state = HALT;
                end else if (is_mem) begin
                    next_state = WAIT_MEM;
                end else begin
                    next_state = FETCH;
                end
            end
            WAIT_MEM:  if (mem_done) next_state = FETCH;
            default:   next_state = HALT;
        endcase
    end

    // Instruction completes in EXEC, or when its data access returns
    assign retire = (state == EXEC && !is_mem && !is_halt) || (state == WAIT_MEM && mem_done);
    assign next_pc = (branch_taken || is_jump) ? pc + imm : pc + 32'd4;

    assign mem_start = (state == EXEC) && is_mem;
    assign rf_we_en  = retire;
    assign halted    = (state == HALT) || (state == EXEC && is_halt);
    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= FETCH;
            pc       <= core_pkg::RESET_PC;
            imem_req <= 1'b0;
        end else begin
            state    <= next_state;
            // Strobe is high for exactly the one cycle spent in FETCH
            imem_req <= (next_state == FETCH);
            if (retire) begin
                pc <= next_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (imem_valid && state == WAIT_INST) begin
            inst <= imem_rdata;
        end
    end

    a_req_in_fetch: assert property (@(posedge clk) disable iff (rst)
        imem_req |-> state == FETCH);
    a_valid_when_waiting: assert property (@(posedge clk) disable iff (rst)
        imem_valid |-> state == WAIT_INST);
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00);

endmodule

// File: hw/isa_pkg.sv
/*
 * ISA package
 * RV32I encodings for the kept subset: major opcodes,
 * ALU operations, branch conditions and memory access sizes
 */
package isa_pkg;

    // Major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_JAL    = 7'b1101111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_SYSTEM = 7'b1110011
    } opcode_t;

    // Internal ALU operation codes
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_SLT = 4'd2,
        ALU_XOR = 4'd3,
        ALU_OR  = 4'd4,
        ALU_AND = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7
    } alu_op_t;

    // Branch conditions, coded as funct3
    typedef enum logic [2:0] {
        BR_EQ = 3'b000,
        BR_NE = 3'b001,
        BR_LT = 3'b100,
        BR_GE = 3'b101
    } branch_t;

    // Load and store sizes, coded as funct3
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_W  = 3'b010,
        MEM_BU = 3'b100
    } mem_size_t;

endpackage

// File: hw/load_store_unit.sv
/*
 * Load/store unit
 * Issues one data memory request per access, places store
 * bytes on their lanes, and extracts and extends load data.
 * Tracks the outstanding access until the memory answers.
 */
module load_store_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      mem_start,
    input  logic                      is_store,
    input  isa_pkg::mem_size_t        mem_size,
    input  logic [core_pkg::XLEN-1:0] addr,
    input  logic [core_pkg::XLEN-1:0] store_data,
    input  logic                      dmem_done,
    input  logic [core_pkg::XLEN-1:0] dmem_rdata,
    output logic                      dmem_req,
    output logic                      dmem_we,
    output logic [core_pkg::XLEN-1:0] dmem_addr,
    output logic [core_pkg::XLEN-1:0] dmem_wdata,
    output logic [3:0]                dmem_wstrb,
    output logic                      mem_done,
    output logic [core_pkg::XLEN-1:0] load_data
);

    logic       busy;
    logic [7:0] load_byte;

    assign dmem_req  = mem_start;
    assign dmem_we   = is_store;
    assign dmem_addr = {addr[core_pkg::XLEN-1:2], 2'b00};

    // Byte stores replicate the byte and enable one lane
    always_comb begin
        if (mem_size == isa_pkg::MEM_W) begin
            dmem_wdata = store_data;
            dmem_wstrb = 4'b1111;
        end else begin
            dmem_wdata = {4{store_data[7:0]}};
            dmem_wstrb = 4'b0001 << addr[1:0];
        end
    end

    // Address and size stay stable while the instruction is held
    assign load_byte = dmem_rdata[8*addr[1:0] +: 8];

    always_comb begin
        case (mem_size)
            isa_pkg::MEM_B:  load_data = {{24{load_byte[7]}}, load_byte};
            isa_pkg::MEM_BU: load_data = {24'b0, load_byte};
            default:         load_data = dmem_rdata;
        endcase
    end

    assign mem_done = dmem_done && busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (mem_start) begin
            busy <= 1'b1;
        end else if (dmem_done) begin
            busy <= 1'b0;
        end
    end

    a_start_when_idle: assert property (@(posedge clk) disable iff (rst)
        mem_start |-> !busy);
    a_done_when_busy: assert property (@(posedge clk) disable iff (rst)
        dmem_done |-> busy);

endmodule

// File: hw/reg_file.sv
/*
 * Register file
 * 32 x 32-bit integer registers, two combinational read
 * ports and one synchronous write port. x0 holds zero.
 */
module reg_file (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs1,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs2,
    input  logic [core_pkg::REG_ADDR_W-1:0] rd,
    input  logic                            we,
    input  logic [core_pkg::XLEN-1:0]       wdata,
    output logic [core_pkg::XLEN-1:0]       rs1_data,
    output logic [core_pkg::XLEN-1:0]       rs2_data
);

    logic [core_pkg::XLEN-1:0] regs [core_pkg::NUM_REGS];

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    // x0 is cleared by reset and never written afterwards
    always_ff @(posedge clk) begin
        if (rst) begin
            regs[0] <= '0;
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // Both read ports return zero for x0
    a_x0_zero: assert property (@(posedge clk) disable iff (rst)
        (rs1 != '0 || rs1_data == '0) && (rs2 != '0 || rs2_data == '0));

endmodule
